// ==== Bender.yml ====
package:
  name: spike_attn

sources:
  - files:
      - source/attn_pkg.sv
      - source/attn_stream_if.sv
      - source/qkv_spike_store.sv
      - source/qk_spike_accum.sv
      - source/attn_score_buffer.sv
      - source/attn_value_mac.sv
      - source/lif_neuron_bank.sv
      - source/spike_attn_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/spike_attn_tb.sv

// ==== dv/attn_ref_model.svh ====
// reference model of the attention core, included inside the testbench module
// it reads the testbench copies in spk_model and the testbench VTH
// plain integer arithmetic, so it assumes no membrane ever exceeds 2**MEM_W - 1
`ifndef ATTN_REF_MODEL_SVH
`define ATTN_REF_MODEL_SVH

    function automatic int count_ones(input logic [DIM-1:0] bits);
        int n;
        n = 0;
        for (int i = 0; i < DIM; i++) begin
            n += int'(bits[i]);
        end
        return n;
    endfunction

    // spikes of one row at time step t, replaying its membranes from step 0
    function automatic logic [DIM-1:0] ref_spikes(input int row, input int t);
        int             mem [DIM];
        int             score;
        int             sum;
        logic [DIM-1:0] spikes;
        spikes = '0;
        for (int ch = 0; ch < DIM; ch++) begin
            mem[ch] = 0;
        end
        for (int tt = 0; tt <= t; tt++) begin
            for (int ch = 0; ch < DIM; ch++) begin
                sum = 0;
                for (int col = 0; col < TOKENS; col++) begin
                    score = count_ones(spk_model[int'(MAT_Q)][tt][row]
                                       & spk_model[int'(MAT_K)][tt][col]);
                    if (spk_model[int'(MAT_V)][tt][col][ch]) begin
                        sum += score;  // the V bit gates the whole score into this channel
                    end
                end
                mem[ch]    = (tt == 0) ? sum : (mem[ch] / 2) + sum;
                spikes[ch] = (mem[ch] >= VTH);
                if (spikes[ch]) begin
                    mem[ch] = 0;
                end
            end
        end
        return spikes;
    endfunction

`endif

// ==== dv/spike_attn_tb.sv ====
// testbench for the spiking attention core
// expected words are computed when each frame starts, so later model changes do not leak in
// runs with VTH and OUT_CREDITS away from their defaults to exercise the parameters
`timescale 1ns/1ns
`default_nettype none

module spike_attn_tb;
    import attn_pkg::*;

    localparam int VTH            = 12;
    localparam int OUT_CREDITS    = 3;
    localparam int WORD_W         = ROW_W + TIME_W + DIM;
    localparam int RUNS           = 6;
    localparam int LOAD_CYCLES    = 3 * TIME_STEPS * TOKENS;
    localparam int TIMEOUT_CYCLES = 4 * RUNS * (TOKENS * TIME_STEPS * TOKENS + LOAD_CYCLES);
    localparam int FILL_RANDOM    = 0;
    localparam int FILL_ZERO      = 1;
    localparam int FILL_ONE       = 2;

    logic              s_clk;
    logic              i_reset;
    logic              i_wr_valid;
    mat_sel_t          i_wr_mat;
    logic [TIME_W-1:0] i_wr_time;
    logic [ROW_W-1:0]  i_wr_row;
    logic [DIM-1:0]    i_wr_data;
    logic              i_start;
    logic              i_out_credit = 1'b0;
    logic              o_busy;
    logic              o_done;
    logic              o_out_valid;
    logic [ROW_W-1:0]  o_out_row;
    logic [TIME_W-1:0] o_out_time;
    logic [DIM-1:0]    o_out_spikes;

    logic [DIM-1:0]    spk_model [3][TIME_STEPS][TOKENS];  // mirror of the spike store
    logic [WORD_W-1:0] exp_q [$];
    logic [31:0]       lfsr_state = 32'hdaafc437;
    logic              slow_credits = 1'b0;
    string             cur_test = "reset";
    int                err_count = 0;
    int                test_err_base = 0;
    int                tests_run = 0;
    int                tests_failed = 0;
    int                done_cnt = 0;
    int                held = 0;         // words whose credit is not yet handed back
    int                outstanding = 0;  // words sent minus credits the DUT has taken
    int                cycle_cnt = 0;

    `include "attn_ref_model.svh"

    spike_attn_top #(
        .VTH         (VTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) i_dut (
        .s_clk        (s_clk),
        .i_reset      (i_reset),
        .i_wr_valid   (i_wr_valid),
        .i_wr_mat     (i_wr_mat),
        .i_wr_time    (i_wr_time),
        .i_wr_row     (i_wr_row),
        .i_wr_data    (i_wr_data),
        .i_start      (i_start),
        .o_busy       (o_busy),
        .o_done       (o_done),
        .i_out_credit (i_out_credit),
        .o_out_valid  (o_out_valid),
        .o_out_row    (o_out_row),
        .o_out_time   (o_out_time),
        .o_out_spikes (o_out_spikes)
    );

    initial begin
        s_clk = 1'b0;
        forever begin
            #4 s_clk = ~s_clk;
        end
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic rand_bit();
        logic fb;
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [DIM-1:0] rand_row();
        logic [DIM-1:0] r;
        for (int i = 0; i < DIM; i++) begin
            r[i] = rand_bit();
        end
        return r;
    endfunction

    task automatic begin_test(input string name);
        cur_test      = name;
        test_err_base = err_count;
    endtask

    task automatic end_test();
        tests_run++;
        if (err_count == test_err_base) begin
            $display("%s: passed", cur_test);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", cur_test, err_count - test_err_base);
        end
    endtask

    task automatic write_row(input mat_sel_t mat, input int t, input int row,
                             input logic [DIM-1:0] data);
        @(posedge s_clk);
        i_wr_valid <= 1'b1;
        i_wr_mat   <= mat;
        i_wr_time  <= TIME_W'(t);
        i_wr_row   <= ROW_W'(row);
        i_wr_data  <= data;
    endtask

    task automatic load_matrix(input mat_sel_t mat, input int fill);
        logic [DIM-1:0] data;
        for (int t = 0; t < TIME_STEPS; t++) begin
            for (int r = 0; r < TOKENS; r++) begin
                case (fill)
                    FILL_ZERO: data = '0;
                    FILL_ONE:  data = '1;
                    default:   data = rand_row();
                endcase
                spk_model[int'(mat)][t][r] = data;
                write_row(mat, t, r, data);
            end
        end
        @(posedge s_clk);
        i_wr_valid <= 1'b0;
    endtask

    task automatic load_frame(input int fill);
        load_matrix(MAT_Q, fill);
        load_matrix(MAT_K, fill);
        load_matrix(MAT_V, fill);
    endtask

    task automatic start_frame();
        exp_q.delete();
        for (int r = 0; r < TOKENS; r++) begin
            for (int t = 0; t < TIME_STEPS; t++) begin
                exp_q.push_back({ROW_W'(r), TIME_W'(t), ref_spikes(r, t)});
            end
        end
        done_cnt = 0;
        @(posedge s_clk);
        i_start <= 1'b1;
        @(posedge s_clk);
        i_start <= 1'b0;
    endtask

    task automatic wait_frame();
        do begin
            @(posedge s_clk);
        end while (o_done !== 1'b1);
        repeat (4) @(posedge s_clk);
        if (done_cnt != 1) begin
            $display("%s: o_done pulsed %0d times in one frame", cur_test, done_cnt);
            err_count++;
        end
        if (o_busy !== 1'b0) begin
            $display("%s: o_busy is still high after o_done", cur_test);
            err_count++;
        end
        if (exp_q.size() != 0) begin
            $display("%s: %0d expected words never came out", cur_test, exp_q.size());
            err_count++;
        end
        while (outstanding != 0) begin
            @(posedge s_clk);
        end
    endtask

    task automatic run_frame();
        start_frame();
        wait_frame();
    endtask

    always @(posedge s_clk) begin : compare_output
        logic [ROW_W-1:0]  exp_row;
        logic [TIME_W-1:0] exp_t;
        logic [DIM-1:0]    exp_spk;
        if (o_out_valid) begin
            if (exp_q.size() == 0) begin
                $display("%s: output word row %0d t %0d arrived with none expected",
                         cur_test, o_out_row, o_out_time);
                err_count++;
            end else begin
                {exp_row, exp_t, exp_spk} = exp_q.pop_front();
                if (o_out_row !== exp_row || o_out_time !== exp_t
                        || o_out_spikes !== exp_spk) begin
                    $display("Mismatch %s: expected row %0d t %0d %h, actual row %0d t %0d %h",
                             cur_test, exp_row, exp_t, exp_spk,
                             o_out_row, o_out_time, o_out_spikes);
                    err_count++;
                end
            end
        end
        if (o_done) begin
            done_cnt++;
            if (o_busy) begin
                $display("%s: o_busy is high in the o_done cycle", cur_test);
                err_count++;
            end
        end
    end

    // the downstream returns credits at once, or after LFSR-chosen gaps
    always @(posedge s_clk) begin : credit_return
        logic [2:0] gap;
        logic       give;
        gap         = 3'b000;
        outstanding = outstanding + int'(o_out_valid) - int'(i_out_credit);
        held        = held + int'(o_out_valid);
        if (outstanding > OUT_CREDITS) begin
            $display("%s: %0d output words outstanding with only %0d credits",
                     cur_test, outstanding, OUT_CREDITS);
            err_count++;
        end
        if (slow_credits && held > 0) begin
            gap = {rand_bit(), rand_bit(), rand_bit()};
        end
        give = (held > 0) && (gap == 3'b000);
        if (give) begin
            held--;
        end
        i_out_credit <= give;
    end

    always @(posedge s_clk) begin : watchdog
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("%s: timeout, the run did not end within %0d cycles",
                     cur_test, TIMEOUT_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        i_reset    = 1'b1;
        i_wr_valid = 1'b0;
        i_wr_mat   = MAT_Q;
        i_wr_time  = '0;
        i_wr_row   = '0;
        i_wr_data  = '0;
        i_start    = 1'b0;
        repeat (8) @(posedge s_clk);
        i_reset <= 1'b0;

        begin_test("reset_idle");
        repeat (20) begin
            @(posedge s_clk);
            if (o_busy !== 1'b0 || o_done !== 1'b0 || o_out_valid !== 1'b0) begin
                $display("reset_idle: o_busy, o_done or o_out_valid is not low while idle");
                err_count++;
            end
        end
        end_test();

        begin_test("random_prompt_credits");
        load_frame(FILL_RANDOM);
        run_frame();
        end_test();

        // same frame again with a slow downstream
        begin_test("random_late_credits");
        slow_credits <= 1'b1;
        run_frame();
        slow_credits <= 1'b0;
        end_test();

        begin_test("corner_frames");
        load_frame(FILL_ZERO);
        run_frame();
        load_frame(FILL_ONE);
        run_frame();
        end_test();

        begin_test("busy_lockout");
        load_frame(FILL_RANDOM);
        start_frame();
        while (o_busy !== 1'b1) begin
            @(posedge s_clk);
        end
        for (int r = 0; r < TOKENS; r++) begin
            write_row(MAT_Q, r % TIME_STEPS, r, rand_row());  // the store must drop these
            write_row(MAT_V, 1, r, rand_row());
        end
        @(posedge s_clk);
        i_wr_valid <= 1'b0;
        i_start    <= 1'b1;
        @(posedge s_clk);
        i_start <= 1'b0;
        wait_frame();
        load_matrix(MAT_V, FILL_RANDOM);
        run_frame();
        end_test();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/attn_pkg.sv ====
// sizes and encodings shared by the attention core and its testbench
// SUM_W and MEM_W are sized for TOKENS*DIM <= 127 and must grow with them
`default_nettype none

package attn_pkg;

    localparam int TIME_STEPS = 4;
    localparam int TIME_W     = 2;
    localparam int TOKENS     = 8;
    localparam int ROW_W      = 3;
    localparam int DIM        = 8;
    localparam int SCORE_W    = 4;  // holds 0 to DIM
    localparam int SUM_W      = 7;  // holds 0 to TOKENS*DIM
    localparam int MEM_W      = 8;

    // one entry per score in flight, so the accumulator starts with this many credits
    localparam int SCORE_BUF_DEPTH = TOKENS;

    typedef enum logic [1:0] {
        MAT_Q = 2'd0,
        MAT_K = 2'd1,
        MAT_V = 2'd2
    } mat_sel_t;

endpackage

`default_nettype wire

// ==== source/attn_score_buffer.sv ====
// circular buffer of tagged scores between the accumulator and the value MAC
// the sender's credits keep it from overflowing, so a write is never refused
// one credit goes back the cycle after each read
`timescale 1ns/1ns
`default_nettype none

module attn_score_buffer (
    input  wire                           s_clk,
    input  wire                           i_reset,
    score_credit_if.receiver              i_score,
    input  wire                           i_rd_en,
    output logic                          o_rd_valid,
    output logic [attn_pkg::SCORE_W-1:0]  o_rd_score,
    output logic [attn_pkg::TIME_W-1:0]   o_rd_t,
    output logic [attn_pkg::ROW_W-1:0]    o_rd_row,
    output logic [attn_pkg::ROW_W-1:0]    o_rd_col
);
    import attn_pkg::*;

    localparam int PTR_W   = $clog2(SCORE_BUF_DEPTH);
    localparam int CNT_W   = $clog2(SCORE_BUF_DEPTH + 1);
    localparam int ENTRY_W = TIME_W + 2 * ROW_W + SCORE_W;

    logic [ENTRY_W-1:0] entries [SCORE_BUF_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   fill;
    logic               rd_fire;

    assign o_rd_valid = (fill != '0);
    assign rd_fire    = i_rd_en && o_rd_valid;
    assign {o_rd_t, o_rd_row, o_rd_col, o_rd_score} = entries[rd_ptr];

    always_ff @(posedge s_clk) begin
        if (i_score.valid) begin
            entries[wr_ptr] <= {i_score.t, i_score.row, i_score.col, i_score.score};
        end
    end

    always_ff @(posedge s_clk) begin
        if (i_reset) begin
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            fill           <= '0;
            i_score.credit <= 1'b0;
        end else begin
            fill           <= fill + CNT_W'(i_score.valid) - CNT_W'(rd_fire);
            i_score.credit <= rd_fire;
            if (i_score.valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(SCORE_BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= (rd_ptr == PTR_W'(SCORE_BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/attn_stream_if.sv ====
// credit-flow links inside the core
// valid is a one-cycle pulse that spends one credit, credit is a one-cycle return
`timescale 1ns/1ns
`default_nettype none

interface score_credit_if;
    import attn_pkg::*;

    logic               valid;
    logic [TIME_W-1:0]  t;
    logic [ROW_W-1:0]   row;
    logic [ROW_W-1:0]   col;
    logic [SCORE_W-1:0] score;
    logic               credit;

    modport sender (output valid, t, row, col, score, input credit);
    modport receiver (input valid, t, row, col, score, output credit);
endinterface

interface sum_credit_if;
    import attn_pkg::*;

    logic                      valid;
    logic [TIME_W-1:0]         t;
    logic [ROW_W-1:0]          row;
    logic [DIM-1:0][SUM_W-1:0] sums;
    logic                      credit;

    modport sender (output valid, t, row, sums, input credit);
    modport receiver (input valid, t, row, sums, output credit);
endinterface

`default_nettype wire

// ==== source/attn_value_mac.sv ====
// multiplies one row of scores by the V spikes, one score per cycle
// a finished group is offered the next cycle and waits there for a sum credit
// reads stall while a group waits, except in the cycle it is sent
`timescale 1ns/1ns
`default_nettype none

module attn_value_mac (
    input  wire                           s_clk,
    input  wire                           i_reset,
    output logic                          o_rd_en,
    input  wire                           i_rd_valid,
    input  wire  [attn_pkg::SCORE_W-1:0]  i_rd_score,
    input  wire  [attn_pkg::TIME_W-1:0]   i_rd_t,
    input  wire  [attn_pkg::ROW_W-1:0]    i_rd_row,
    input  wire  [attn_pkg::ROW_W-1:0]    i_rd_col,
    output logic [attn_pkg::TIME_W-1:0]   o_v_time,
    output logic [attn_pkg::ROW_W-1:0]    o_v_row,
    input  wire  [attn_pkg::DIM-1:0]      i_v_row,
    sum_credit_if.sender                  o_sum
);
    import attn_pkg::*;

    logic [DIM-1:0][SUM_W-1:0] acc;
    logic                      pending;
    logic [TIME_W-1:0]         grp_t;
    logic [ROW_W-1:0]          grp_row;
    logic [1:0]                credits;
    logic                      send;

    assign send    = pending && (credits != '0);
    assign o_rd_en = i_rd_valid && (!pending || send);

    // the score column selects which V row multiplies it
    assign o_v_time = i_rd_t;
    assign o_v_row  = i_rd_col;

    assign o_sum.valid = send;
    assign o_sum.t     = grp_t;
    assign o_sum.row   = grp_row;
    assign o_sum.sums  = acc;

    always_ff @(posedge s_clk) begin
        if (i_reset) begin
            pending <= 1'b0;
            credits <= 2'd1;
        end else begin
            credits <= credits - 2'(send) + 2'(o_sum.credit);
            if (send) begin
                pending <= 1'b0;
            end
            if (o_rd_en && (i_rd_col == ROW_W'(TOKENS - 1))) begin
                pending <= 1'b1;
            end
        end
    end

    // column 0 starts a fresh group, which also clears the sums that were just sent
    always_ff @(posedge s_clk) begin
        if (o_rd_en) begin
            for (int ch = 0; ch < DIM; ch++) begin
                acc[ch] <= ((i_rd_col == '0) ? '0 : acc[ch])
                         + (i_v_row[ch] ? SUM_W'(i_rd_score) : '0);
            end
            grp_t   <= i_rd_t;
            grp_row <= i_rd_row;
        end
    end

endmodule

`default_nettype wire

// ==== source/lif_neuron_bank.sv ====
// leaky integrate-and-fire neurons, one per channel, reloaded at time step 0
// VTH must lie between 1 and 2**MEM_W - 1
// the sum credit goes back in the cycle the output word leaves
`timescale 1ns/1ns
`default_nettype none

module lif_neuron_bank #(
    parameter int VTH         = 16,
    parameter int OUT_CREDITS = 4
) (
    input  wire                           s_clk,
    input  wire                           i_reset,
    sum_credit_if.receiver                i_sum,
    input  wire                           i_out_credit,
    output logic                          o_out_valid,
    output logic [attn_pkg::ROW_W-1:0]    o_out_row,
    output logic [attn_pkg::TIME_W-1:0]   o_out_time,
    output logic [attn_pkg::DIM-1:0]      o_out_spikes,
    output logic                          o_frame_end
);
    import attn_pkg::*;

    localparam int CRED_W = $clog2(OUT_CREDITS + 1);

    logic [DIM-1:0][MEM_W-1:0] membrane;
    logic [DIM-1:0][MEM_W-1:0] mem_next;
    logic [DIM-1:0]            fire;
    logic                      word_pending;
    logic [CRED_W-1:0]         out_credits;

    always_comb begin
        for (int ch = 0; ch < DIM; ch++) begin
            mem_next[ch] = ((i_sum.t == '0) ? '0 : (membrane[ch] >> 1))
                         + MEM_W'(i_sum.sums[ch]);
            fire[ch] = (mem_next[ch] >= VTH);
        end
    end

    assign o_out_valid  = word_pending && (out_credits != '0);
    assign i_sum.credit = o_out_valid;
    assign o_frame_end  = o_out_valid && (o_out_row == ROW_W'(TOKENS - 1))
                        && (o_out_time == TIME_W'(TIME_STEPS - 1));

    always_ff @(posedge s_clk) begin
        if (i_reset) begin
            word_pending <= 1'b0;
            out_credits  <= CRED_W'(OUT_CREDITS);
        end else begin
            out_credits <= out_credits - CRED_W'(o_out_valid) + CRED_W'(i_out_credit);
            if (i_sum.valid) begin
                word_pending <= 1'b1;
            end else if (o_out_valid) begin
                word_pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge s_clk) begin
        if (i_sum.valid) begin
            for (int ch = 0; ch < DIM; ch++) begin
                membrane[ch] <= fire[ch] ? '0 : mem_next[ch];  // a spike resets to zero
            end
            o_out_spikes <= fire;
            o_out_row    <= i_sum.row;
            o_out_time   <= i_sum.t;
        end
    end

endmodule

`default_nettype wire

// ==== source/qk_spike_accum.sv ====
// run controller and query-key score generator
// scores leave in row, time step, column order, at most one per cycle per credit
// o_busy holds until the neuron bank reports that the last output word left
`timescale 1ns/1ns
`default_nettype none

module qk_spike_accum (
    input  wire                           s_clk,
    input  wire                           i_reset,
    input  wire                           i_start,
    output logic                          o_busy,
    output logic                          o_done,
    input  wire                           i_frame_end,
    output logic [attn_pkg::TIME_W-1:0]   o_q_time,
    output logic [attn_pkg::ROW_W-1:0]    o_q_row,
    input  wire  [attn_pkg::DIM-1:0]      i_q_row,
    output logic [attn_pkg::TIME_W-1:0]   o_k_time,
    output logic [attn_pkg::ROW_W-1:0]    o_k_row,
    input  wire  [attn_pkg::DIM-1:0]      i_k_row,
    score_credit_if.sender                o_score
);
    import attn_pkg::*;

    localparam int CRED_W = $clog2(SCORE_BUF_DEPTH + 1);

    logic               issuing;
    logic [CRED_W-1:0]  credits;
    logic [ROW_W-1:0]   row_cnt;
    logic [TIME_W-1:0]  t_cnt;
    logic [ROW_W-1:0]   col_cnt;
    logic [SCORE_W-1:0] match_cnt;
    logic               fire;
    logic               last_col;
    logic               last_t;

    assign o_q_time = t_cnt;
    assign o_q_row  = row_cnt;
    assign o_k_time = t_cnt;
    assign o_k_row  = col_cnt;  // key row index walks the score columns

    assign fire     = issuing && (credits != '0);
    assign last_col = (col_cnt == ROW_W'(TOKENS - 1));
    assign last_t   = (t_cnt == TIME_W'(TIME_STEPS - 1));

    always_comb begin
        match_cnt = '0;
        for (int i = 0; i < DIM; i++) begin
            match_cnt = match_cnt + SCORE_W'(i_q_row[i] & i_k_row[i]);
        end
    end

    always_ff @(posedge s_clk) begin
        if (i_reset) begin
            o_busy  <= 1'b0;
            o_done  <= 1'b0;
            issuing <= 1'b0;
            credits <= CRED_W'(SCORE_BUF_DEPTH);
            row_cnt <= '0;
            t_cnt   <= '0;
            col_cnt <= '0;
        end else begin
            o_done  <= 1'b0;
            credits <= credits - CRED_W'(fire) + CRED_W'(o_score.credit);
            if (i_start && !o_busy) begin
                o_busy  <= 1'b1;
                issuing <= 1'b1;
                row_cnt <= '0;
                t_cnt   <= '0;
                col_cnt <= '0;
            end else if (o_busy && i_frame_end) begin
                o_busy <= 1'b0;  // done and busy change in the same cycle
                o_done <= 1'b1;
            end
            if (fire) begin
                col_cnt <= last_col ? '0 : col_cnt + 1'b1;
                if (last_col) begin
                    t_cnt <= last_t ? '0 : t_cnt + 1'b1;
                    if (last_t) begin
                        row_cnt <= row_cnt + 1'b1;
                        if (row_cnt == ROW_W'(TOKENS - 1)) begin
                            issuing <= 1'b0;
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge s_clk) begin
        if (i_reset) begin
            o_score.valid <= 1'b0;
        end else begin
            o_score.valid <= fire;
        end
    end

    always_ff @(posedge s_clk) begin
        if (fire) begin
            o_score.t     <= t_cnt;
            o_score.row   <= row_cnt;
            o_score.col   <= col_cnt;
            o_score.score <= match_cnt;
        end
    end

endmodule

`default_nettype wire

// ==== source/qkv_spike_store.sv ====
// Q, K and V spike rows for every time step, written one row per cycle
// writes are dropped while i_lock is high or for an unused matrix code
// reads are combinational, so data written at an edge is visible right after it
`timescale 1ns/1ns
`default_nettype none

module qkv_spike_store (
    input  wire                           s_clk,
    input  wire                           i_reset,
    input  wire                           i_wr_valid,
    input  wire attn_pkg::mat_sel_t       i_wr_mat,
    input  wire  [attn_pkg::TIME_W-1:0]   i_wr_time,
    input  wire  [attn_pkg::ROW_W-1:0]    i_wr_row,
    input  wire  [attn_pkg::DIM-1:0]      i_wr_data,
    input  wire                           i_lock,
    input  wire  [attn_pkg::TIME_W-1:0]   i_q_time,
    input  wire  [attn_pkg::ROW_W-1:0]    i_q_row,
    output logic [attn_pkg::DIM-1:0]      o_q_row,
    input  wire  [attn_pkg::TIME_W-1:0]   i_k_time,
    input  wire  [attn_pkg::ROW_W-1:0]    i_k_row,
    output logic [attn_pkg::DIM-1:0]      o_k_row,
    input  wire  [attn_pkg::TIME_W-1:0]   i_v_time,
    input  wire  [attn_pkg::ROW_W-1:0]    i_v_row,
    output logic [attn_pkg::DIM-1:0]      o_v_row
);
    import attn_pkg::*;

    logic [DIM-1:0] spikes [3][TIME_STEPS][TOKENS];  // first index is the matrix select

    always_ff @(posedge s_clk) begin
        if (i_reset) begin
            for (int m = 0; m < 3; m++) begin
                for (int t = 0; t < TIME_STEPS; t++) begin
                    for (int r = 0; r < TOKENS; r++) begin
                        spikes[m][t][r] <= '0;
                    end
                end
            end
        end else if (i_wr_valid && !i_lock && (i_wr_mat <= MAT_V)) begin
            spikes[i_wr_mat][i_wr_time][i_wr_row] <= i_wr_data;
        end
    end

    assign o_q_row = spikes[MAT_Q][i_q_time][i_q_row];
    assign o_k_row = spikes[MAT_K][i_k_time][i_k_row];
    assign o_v_row = spikes[MAT_V][i_v_time][i_v_row];

endmodule

`default_nettype wire

// ==== source/spike_attn_top.sv ====
// single-head spiking self-attention core
// load Q, K and V while idle, then pulse i_start; TOKENS*TIME_STEPS words follow
// the downstream pulses i_out_credit once per accepted word
`timescale 1ns/1ns
`default_nettype none

module spike_attn_top #(
    parameter int VTH         = 16,
    parameter int OUT_CREDITS = 4
) (
    input  wire                           s_clk,
    input  wire                           i_reset,
    input  wire                           i_wr_valid,
    input  wire attn_pkg::mat_sel_t       i_wr_mat,
    input  wire  [attn_pkg::TIME_W-1:0]   i_wr_time,
    input  wire  [attn_pkg::ROW_W-1:0]    i_wr_row,
    input  wire  [attn_pkg::DIM-1:0]      i_wr_data,
    input  wire                           i_start,
    output logic                          o_busy,
    output logic                          o_done,
    input  wire                           i_out_credit,
    output logic                          o_out_valid,
    output logic [attn_pkg::ROW_W-1:0]    o_out_row,
    output logic [attn_pkg::TIME_W-1:0]   o_out_time,
    output logic [attn_pkg::DIM-1:0]      o_out_spikes
);
    import attn_pkg::*;

    logic [TIME_W-1:0]  q_time, k_time, v_time;
    logic [ROW_W-1:0]   q_idx, k_idx, v_idx;
    logic [DIM-1:0]     q_spikes, k_spikes, v_spikes;
    logic               rd_en, rd_valid;
    logic [SCORE_W-1:0] rd_score;
    logic [TIME_W-1:0]  rd_t;
    logic [ROW_W-1:0]   rd_row, rd_col;
    logic               frame_end;

    score_credit_if u_score_if ();
    sum_credit_if   u_sum_if ();

    qkv_spike_store u_store (
        .s_clk      (s_clk),
        .i_reset    (i_reset),
        .i_wr_valid (i_wr_valid),
        .i_wr_mat   (i_wr_mat),
        .i_wr_time  (i_wr_time),
        .i_wr_row   (i_wr_row),
        .i_wr_data  (i_wr_data),
        .i_lock     (o_busy),
        .i_q_time   (q_time),
        .i_q_row    (q_idx),
        .o_q_row    (q_spikes),
        .i_k_time   (k_time),
        .i_k_row    (k_idx),
        .o_k_row    (k_spikes),
        .i_v_time   (v_time),
        .i_v_row    (v_idx),
        .o_v_row    (v_spikes)
    );

    qk_spike_accum u_accum (
        .s_clk       (s_clk),
        .i_reset     (i_reset),
        .i_start     (i_start),
        .o_busy      (o_busy),
        .o_done      (o_done),
        .i_frame_end (frame_end),
        .o_q_time    (q_time),
        .o_q_row     (q_idx),
        .i_q_row     (q_spikes),
        .o_k_time    (k_time),
        .o_k_row     (k_idx),
        .i_k_row     (k_spikes),
        .o_score     (u_score_if.sender)
    );

    attn_score_buffer u_score_buf (
        .s_clk      (s_clk),
        .i_reset    (i_reset),
        .i_score    (u_score_if.receiver),
        .i_rd_en    (rd_en),
        .o_rd_valid (rd_valid),
        .o_rd_score (rd_score),
        .o_rd_t     (rd_t),
        .o_rd_row   (rd_row),
        .o_rd_col   (rd_col)
    );

    attn_value_mac u_mac (
        .s_clk      (s_clk),
        .i_reset    (i_reset),
        .o_rd_en    (rd_en),
        .i_rd_valid (rd_valid),
        .i_rd_score (rd_score),
        .i_rd_t     (rd_t),
        .i_rd_row   (rd_row),
        .i_rd_col   (rd_col),
        .o_v_time   (v_time),
        .o_v_row    (v_idx),
        .i_v_row    (v_spikes),
        .o_sum      (u_sum_if.sender)
    );

    lif_neuron_bank #(
        .VTH         (VTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) u_lif (
        .s_clk        (s_clk),
        .i_reset      (i_reset),
        .i_sum        (u_sum_if.receiver),
        .i_out_credit (i_out_credit),
        .o_out_valid  (o_out_valid),
        .o_out_row    (o_out_row),
        .o_out_time   (o_out_time),
        .o_out_spikes (o_out_spikes),
        .o_frame_end  (frame_end)
    );

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+dv
source/attn_pkg.sv
source/attn_stream_if.sv
source/qkv_spike_store.sv
source/qk_spike_accum.sv
source/attn_score_buffer.sv
source/attn_value_mac.sv
source/lif_neuron_bank.sv
source/spike_attn_top.sv
dv/spike_attn_tb.sv
